/* compile.f */
src/mem_pkg.sv
src/req_issuer.sv
src/req_fifo.sv
src/mem_model.sv
src/mem_subsys_top.sv
tb/tb_mem_subsys.sv

/* src/mem_model.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_model
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     head_valid,
    input  wire mem_req_t head_req,
    output logic          pop,

    output mem_rsp_t      rsp
);

    typedef logic [$clog2(READ_DELAY + WRITE_DELAY)-1:0] delay_t;

    logic [31:0] mem [MEM_WORDS];

    mem_req_t  cmd;       // command in service
    logic      busy;
    delay_t    delay_cnt;
    logic      finish;
    logic      rsp_valid;
    mem_line_u rsp_line;

    logic [ADDR_W-1:0] word_addr;

    // one command at a time, the next one is taken once busy drops
    assign pop    = head_valid && !busy;
    assign finish = busy && (delay_cnt == '0);

    assign word_addr = cmd.addr[ADDR_W-1:0]; // upper address bits alias onto the array

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy      <= 1'b0;
            delay_cnt <= '0;
        end else if (pop) begin
            busy <= 1'b1;
            // counts down to zero, the command completes on the edge after that
            if (head_req.op == OP_READ) begin
                delay_cnt <= delay_t'(READ_DELAY - 1);
            end else begin
                delay_cnt <= delay_t'(WRITE_DELAY - 1);
            end
        end else if (finish) begin
            busy <= 1'b0;
        end else if (busy) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cmd <= head_req;
        end
    end

    // array write and line assembly
    always_ff @(posedge clk) begin
        if (finish && cmd.op == OP_WRITE) begin
            mem[word_addr] <= cmd.wdata;
        end
        if (finish && cmd.op == OP_READ) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                rsp_line.words[i] <= mem[{word_addr[ADDR_W-1:2], 2'(i)}];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= finish && (cmd.op == OP_READ); // one pulse per read
        end
    end

    assign rsp.valid = rsp_valid;
    assign rsp.line  = rsp_line;

    // even back-to-back reads are a full delay apart
    assert property (@(posedge clk) disable iff (!rst)
        rsp_valid |=> !rsp_valid)
        else $error("read response valid on two consecutive cycles");

endmodule

`default_nettype wire

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int MEM_WORDS   = 1024; // 32-bit words in the array
    localparam int ADDR_W      = 10;
    localparam int LINE_WORDS  = 4;
    localparam int FIFO_DEPTH  = 4;    // also the credit count after reset
    localparam int CREDIT_W    = 3;
    localparam int READ_DELAY  = 10;
    localparam int WRITE_DELAY = 10;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    // addr is a word address, only the low ADDR_W bits reach the array
    typedef struct packed {
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // word 0 sits in the low lanes and holds the lowest address of the line
    typedef union packed {
        logic [LINE_WORDS*32-1:0]       vec;
        logic [LINE_WORDS-1:0][31:0]    words;
    } mem_line_u;

    typedef struct packed {
        logic      valid;
        mem_line_u line;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* src/mem_subsys_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     cpu_valid,
    input  wire mem_req_t cpu_req,
    output logic          cpu_ready,

    output mem_rsp_t      rsp
);

    logic     push;
    mem_req_t push_req;
    logic     head_valid;
    mem_req_t head_req;
    logic     pop;
    logic     credit;

    // commands enter here and are throttled by the queue's free slots
    req_issuer i_req_issuer (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .credit    (credit),
        .push      (push),
        .push_req  (push_req)
    );

    req_fifo i_req_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_req   (push_req),
        .head_valid (head_valid),
        .head_req   (head_req),
        .pop        (pop),
        .credit     (credit)
    );

    mem_model i_mem_model (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head_req   (head_req),
        .pop        (pop),
        .rsp        (rsp)
    );

endmodule

`default_nettype wire

/* src/req_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module req_fifo
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     push,
    input  wire mem_req_t push_req,

    output logic          head_valid,
    output mem_req_t      head_req,
    input  wire logic     pop,

    output logic          credit
);

    mem_req_t entries [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [CREDIT_W-1:0]           count;
    logic                          full;

    assign full       = (count == CREDIT_W'(FIFO_DEPTH));
    assign head_valid = (count != '0);
    assign head_req   = entries[rd_ptr]; // oldest entry, valid only with head_valid

    // every entry handed on frees one slot, so the issuer may spend it again
    assign credit = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the issuer only pushes with a credit in hand, so a full queue never sees a push
    assert property (@(posedge clk) disable iff (!rst)
        full |-> !push)
        else $error("push into a full request queue");

    assert property (@(posedge clk) disable iff (!rst)
        !head_valid |-> !pop)
        else $error("pop from an empty request queue");

endmodule

`default_nettype wire

/* src/req_issuer.sv */
`timescale 1ns/10ps
`default_nettype none

module req_issuer
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire logic     cpu_valid,
    input  wire mem_req_t cpu_req,
    output logic          cpu_ready,

    input  wire logic     credit,
    output logic          push,
    output mem_req_t      push_req
);

    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credits_next;
    logic                accept;

    // one free slot in the queue is enough to take a command
    assign cpu_ready = (credits != '0);
    assign accept    = cpu_valid && cpu_ready;

    always_comb begin
        credits_next = credits;
        case ({credit, accept})
            2'b10:   credits_next = credits + 1'b1;
            2'b01:   credits_next = credits - 1'b1;
            default: credits_next = credits; // both or neither cancel out
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
            push    <= 1'b0;
        end else begin
            credits <= credits_next;
            push    <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_req <= cpu_req; // held for the push cycle only
        end
    end

    // a credit coming back while all are home means the queue lost track of an entry
    assert property (@(posedge clk) disable iff (!rst)
        credits <= CREDIT_W'(FIFO_DEPTH))
        else $error("credit count above queue depth");

    assert property (@(posedge clk) disable iff (!rst)
        (credits == CREDIT_W'(FIFO_DEPTH)) |-> !credit)
        else $error("credit returned with no command outstanding");

endmodule

`default_nettype wire

/* tb/mem_tests.txt */
# columns: name, mode (S single, B starts a burst, + continues it), op (R or W), word address
# then write data (hex, or r for random) and the expected read line (hex, or - from the write shadow)
line_w0   S W 00000010 11110000 -
line_w1   S W 00000011 22220001 -
line_w2   S W 00000012 33330002 -
line_w3   S W 00000013 44440003 -
line_rd   S R 00000010 0        44440003333300022222000111110000
off_rd1   S R 00000011 0        44440003333300022222000111110000
off_rd2   S R 00000012 0        44440003333300022222000111110000
off_rd3   S R 00000013 0        44440003333300022222000111110000
rew_w     S W 00000012 a5a5c3c3 -
rew_rd    S R 00000010 0        44440003a5a5c3c32222000111110000
rew_rd_hi S R 00000013 0        44440003a5a5c3c32222000111110000
rnd_w0    S W 00000020 r        -
rnd_w1    S W 00000021 r        -
rnd_w2    S W 00000022 r        -
rnd_w3    S W 00000023 r        -
rnd_rd    S R 00000022 0        -
bst_w0    B W 00000040 r        -
bst_w1    + W 00000041 r        -
bst_r0    + R 00000010 0        -
bst_w2    + W 00000042 r        -
bst_w3    + W 00000043 r        -
bst_r1    + R 00000041 0        -
al_w4     S W 00000004 r        -
al_w5     S W 00000405 r        -
al_w6     S W 00000006 r        -
al_w7     S W fffffc07 r        -
al_rd     S R 00000005 0        -
al_fx     S W 00000c05 0badf00d -
al_fx_rd  S R 00000004 0        -
rb_r0     B R 00000010 0        -
rb_r1     + R 00000020 0        -
rb_r2     + R 00000043 0        -
rb_r3     + R 00000006 0        -
rb_r4     + R 00000013 0        -
rb_r5     + R 00000021 0        -

/* tb/tb_mem_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys
    import mem_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 8;
    localparam int IDLE_LIMIT = 200; // cycles allowed for outstanding reads to drain

    logic     clk;
    logic     rst;
    logic     cpu_valid;
    mem_req_t cpu_req;
    logic     cpu_ready;
    mem_rsp_t rsp;

    // test table as read from the data file
    string       t_name[$];
    string       t_mode[$];
    string       t_op[$];
    logic [31:0] t_addr[$];
    string       t_wdata[$];
    string       t_exp[$];

    // reads in flight, oldest first
    string        exp_name[$];
    logic [127:0] exp_line[$];

    logic [31:0]  shadow [MEM_WORDS];
    integer       seed;
    int           pass_count;
    int           fail_count;
    bit           tests_loaded;
    bit           file_ok;
    bit           stalled;
    int           ti;
    int           burst_start;
    string        mon_name;
    logic [127:0] mon_exp;

    mem_subsys_top i_mem_subsys_top (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .rsp       (rsp)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_tests(output bit ok);
        int                fd;
        int                code;
        string             tok;
        string             mode;
        string             op;
        string             wd;
        string             ex;
        logic [31:0]       addr;
        logic [8*200-1:0]  rest;
        ok = 1'b0;
        fd = $fopen("tb/mem_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/mem_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1) begin
                if (tok[0] == "#") begin
                    code = $fgets(rest, fd); // skip the rest of a comment line
                end else begin
                    code = $fscanf(fd, "%s %s %h %s %s", mode, op, addr, wd, ex);
                    if (code != 5) begin
                        $display("malformed line in test data at %s", tok);
                        $fclose(fd);
                        return;
                    end
                    t_name.push_back(tok);
                    t_mode.push_back(mode);
                    t_op.push_back(op);
                    t_addr.push_back(addr);
                    t_wdata.push_back(wd);
                    t_exp.push_back(ex);
                end
            end
        end
        $fclose(fd);
        ok = (t_name.size() > 0);
    endtask

    // the line holding addr as the memory should return it, lowest word in the low lanes
    function automatic logic [127:0] shadow_line(input logic [31:0] addr);
        int           idx;
        int           base;
        logic [127:0] line;
        idx  = int'(addr % MEM_WORDS);
        base = idx - (idx % LINE_WORDS);
        for (int k = 0; k < LINE_WORDS; k++) begin
            line[k*32 +: 32] = shadow[base + k];
        end
        return line;
    endfunction

    task automatic build_req(input int i, output mem_req_t req);
        logic [31:0] wd;
        int          code;
        wd = '0;
        if (t_wdata[i] == "r") begin
            wd = $random(seed);
        end else begin
            code = $sscanf(t_wdata[i], "%h", wd);
        end
        req.op    = (t_op[i] == "W") ? OP_WRITE : OP_READ;
        req.addr  = t_addr[i];
        req.wdata = wd;
    endtask

    task automatic note_accept(input int i, input mem_req_t req);
        logic [127:0] line;
        int           code;
        if (req.op == OP_WRITE) begin
            shadow[int'(req.addr % MEM_WORDS)] = req.wdata;
            $display("PASS %s write accepted", t_name[i]);
            pass_count++;
        end else begin
            if (t_exp[i] == "-") begin
                line = shadow_line(req.addr);
            end else begin
                code = $sscanf(t_exp[i], "%h", line);
            end
            exp_name.push_back(t_name[i]);
            exp_line.push_back(line);
        end
    endtask

    // entered 0.5 ns after a rising edge and leaves at the same point of a later cycle
    task automatic send_req(input int i, inout bit saw_stall);
        mem_req_t req;
        build_req(i, req);
        cpu_req   = req;
        cpu_valid = 1'b1;
        @(negedge clk);
        while (!cpu_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        note_accept(i, req); // transfers on the coming rising edge
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_idle(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((exp_name.size() != 0 || !cpu_ready) && cycles < IDLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_name.size() != 0) begin
            foreach (exp_name[k]) begin
                $display("no response arrived for read %s", exp_name[k]);
                fail_count++;
            end
            exp_name.delete();
            exp_line.delete();
        end else if (!cpu_ready) begin
            $display("cpu_ready stayed low after %s", what);
            fail_count++;
        end
        @(posedge clk);
        #0.5;
    endtask

    // responses are compared in request order
    always @(negedge clk) begin
        if (rst && rsp.valid === 1'b1) begin
            if (exp_name.size() == 0) begin
                $display("read response arrived with no read outstanding");
                fail_count++;
            end else begin
                mon_name = exp_name.pop_front();
                mon_exp  = exp_line.pop_front();
                if (rsp.line.vec !== mon_exp) begin
                    $display("[ERROR] %s: expected %h, actual %h", mon_name, mon_exp,
                        rsp.line.vec);
                    fail_count++;
                end else begin
                    $display("PASS %s", mon_name);
                    pass_count++;
                end
            end
        end
    end

    initial begin
        seed         = 32'hb27a_45f5;
        rst          = 1'b0;
        cpu_valid    = 1'b0;
        cpu_req      = '0;
        pass_count   = 0;
        fail_count   = 0;
        tests_loaded = 1'b0;
        load_tests(file_ok);
        if (!file_ok) begin
            $display("test data missing or malformed, no tests run");
            fail_count++;
        end
        tests_loaded = file_ok;

        repeat (RST_CYCLES) @(posedge clk);
        #0.5 rst = 1'b1;
        @(negedge clk);
        if (cpu_ready !== 1'b1 || rsp.valid !== 1'b0) begin
            $display("[ERROR] reset_state: expected ready=1 valid=0, actual ready=%b valid=%b",
                cpu_ready, rsp.valid);
            fail_count++;
        end else begin
            $display("PASS reset_state");
            pass_count++;
        end
        @(posedge clk);
        #0.5;

        ti = 0;
        while (file_ok && ti < t_name.size()) begin
            stalled = 1'b0;
            if (t_mode[ti] == "B") begin
                burst_start = ti;
                send_req(ti, stalled);
                ti++;
                while (ti < t_name.size() && t_mode[ti] == "+") begin
                    send_req(ti, stalled); // valid stays high between commands
                    ti++;
                end
                cpu_valid = 1'b0;
                wait_idle({"burst ", t_name[burst_start]});
                if (!stalled) begin
                    $display("cpu_ready never dropped during burst %s", t_name[burst_start]);
                    fail_count++;
                end else begin
                    $display("PASS burst %s back-pressure", t_name[burst_start]);
                    pass_count++;
                end
            end else begin
                send_req(ti, stalled);
                cpu_valid = 1'b0;
                wait_idle(t_name[ti]);
                ti++;
            end
        end

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // budget counts from time zero, so it covers the reset phase as well
    initial begin
        wait (tests_loaded);
        #((t_name.size() * (READ_DELAY + 20) + RST_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish within their time budget");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
